/* vlog.f */
hw/gpio_pkg.sv
hw/apb_decode.sv
hw/gpio_port.sv
hw/irq_ctrl.sv
hw/gpio_subsys.sv
test/gpio_subsys_asserts.sv
test/tb_gpio_subsys.sv

/* run.sh */
#!/usr/bin/env bash
# compile with Verilator, run the testbench and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_gpio_subsys -f vlog.f -o sim_tb \
  || { echo "build failed"; exit 1; }
./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
grep -qx "STATUS: PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* test/tb_gpio_subsys.sv */
`timescale 1ns/1ps

module tb_gpio_subsys
  import gpio_pkg::*;
();

  localparam int e_width    = 4;
  localparam int n_input    = 2;
  localparam int n_output   = 1;
  localparam int n_src      = e_width * n_input;
  localparam int o_width    = e_width * n_output;
  localparam int wait_limit = 50;

  logic               clk;
  logic               anrst;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [11:0]        paddr;
  logic [31:0]        pwdata;
  logic [31:0]        prdata;
  logic               pready;
  logic               pslverr;
  logic [n_src-1:0]   gpio_in;
  logic [o_width-1:0] gpio_out;
  logic               irq;

  // reference model of the register state.
  logic [31:0]      lcg_state = 32'he07f;
  logic [31:0]      led_ref;
  logic [n_src-1:0] latch_ref;
  logic [n_src-1:0] enable_ref;
  string            test_name;

  gpio_subsys #(
    .e_width  (e_width),
    .n_input  (n_input),
    .n_output (n_output)
  ) gpio_subsys_i (
    .clk      (clk),
    .anrst    (anrst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .irq      (irq)
  );

  bind gpio_subsys gpio_subsys_asserts #(
    .n_src   (n_src),
    .o_width (e_width * n_output)
  ) asserts_i (
    .clk      (clk),
    .anrst    (anrst),
    .psel     (psel),
    .paddr    (paddr),
    .pready   (pready),
    .pslverr  (pslverr),
    .gpio_out (gpio_out),
    .irq      (irq),
    .pending  (pending),
    .enable   (irq_ctrl_i.enable),
    .complete (complete)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [11:0] gpio_reg(input logic [3:0] off);
    return gpio_win_base | {8'h00, off};
  endfunction

  function automatic logic [11:0] irq_reg(input logic [3:0] off);
    return irq_win_base | {8'h00, off};
  endfunction

  function automatic logic unmapped(input logic [11:0] addr);
    return addr[11:8] != gpio_win_base[11:8] && addr[11:8] != irq_win_base[11:8];
  endfunction

  // the claim rule: lowest index wins, nothing pending gives no_source.
  function automatic logic [31:0] lowest_index(input logic [n_src-1:0] bits);
    logic [31:0] idx;
    logic        found;
    idx = no_source;
    found = 1'b0;
    for (int i = 0; i < n_src; i++) begin
      if (bits[i] && !found) begin
        idx = 32'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_now($sformatf("** Error %s %s: expected %h, actual %h",
                         test_name, what, expected, actual));
    end
  endtask

  task automatic apb_xfer(input logic is_write, input logic [11:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    int   n;
    logic done;
    n = 0;
    done = 1'b0;
    rdata = '0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= is_write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    while (!done && n < wait_limit) begin
      @(negedge clk);
      if (pready) begin
        done = 1'b1;
        rdata = prdata;
        check_value("pslverr", 32'(unmapped(addr)), 32'(pslverr));
      end
      @(posedge clk);
      n++;
    end
    if (!done) begin
      fail_now("APB transfer timed out waiting for pready");
    end else begin
      psel    <= 1'b0;
      penable <= 1'b0;
    end
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, unused);
  endtask

  task automatic read_check(input logic [11:0] addr, input logic [31:0] expected,
                            input string what);
    logic [31:0] rdata;
    apb_xfer(1'b0, addr, '0, rdata);
    check_value(what, expected, rdata);
  endtask

  task automatic check_latches();
    read_check(gpio_reg(reg_sw), 32'(latch_ref[0 +: e_width]), "reg_sw");
    read_check(gpio_reg(reg_btn), 32'(latch_ref[e_width +: e_width]), "reg_btn");
  endtask

  task automatic wait_raw(input logic [31:0] level);
    logic [31:0] raw;
    int          n;
    n = 0;
    raw = ~level;
    while (raw != level && n < wait_limit) begin
      apb_xfer(1'b0, gpio_reg(reg_raw), '0, raw);
      n++;
    end
    if (raw != level) begin
      fail_now("reg_raw never reached the level driven on gpio_in");
    end
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    @(negedge clk);
    while (irq !== level && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (irq !== level) begin
      fail_now($sformatf("irq did not settle to %0b in time", level));
    end else begin
      @(posedge clk);
    end
  endtask

  always @(negedge clk) begin
    if (gpio_subsys_i.asserts_i.failed) begin
      fail_now("a concurrent assertion on the DUT failed");
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  initial begin
    logic [31:0] value;
    logic [31:0] id;
    anrst   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    gpio_in = '0;
    led_ref    = '0;
    latch_ref  = '0;
    enable_ref = '0;
    repeat (10) @(posedge clk);
    anrst <= 1'b1;
    @(negedge clk);

    test_name = "reset";
    check_value("gpio_out", 32'h0, 32'(gpio_out));
    check_value("irq", 32'h0, 32'(irq));
    check_value("pending", 32'h0, 32'(gpio_subsys_i.pending));
    check_latches();
    read_check(gpio_reg(reg_led), 32'h0, "reg_led");
    read_check(gpio_reg(reg_raw), 32'h0, "reg_raw");
    read_check(irq_reg(reg_enable), 32'h0, "reg_enable");
    read_check(irq_reg(reg_claim), no_source, "reg_claim");

    test_name = "led";
    repeat (4) begin
      value = lcg_next();
      apb_write(gpio_reg(reg_led), value);
      led_ref = value & 32'((1 << o_width) - 1);
      read_check(gpio_reg(reg_led), led_ref, "reg_led");
      check_value("gpio_out", led_ref, 32'(gpio_out));
    end

    test_name = "edge";
    value = 32'(n_src'(lcg_next()));
    if (value == 0) begin
      value = 32'h1;
    end
    gpio_in <= value[n_src-1:0];
    wait_raw(value);
    latch_ref = value[n_src-1:0];
    check_latches();
    gpio_in <= '0;
    wait_raw(32'h0);
    check_latches();

    // make sure at least one latched bit is enabled.
    test_name = "irq";
    enable_ref = n_src'(lcg_next()) | (latch_ref & (~latch_ref + n_src'(1)));
    apb_write(irq_reg(reg_enable), 32'(enable_ref));
    read_check(irq_reg(reg_enable), 32'(enable_ref), "reg_enable");
    wait_irq(1'b1);
    read_check(irq_reg(reg_claim), lowest_index(latch_ref & enable_ref), "reg_claim");
    apb_write(irq_reg(reg_enable), 32'h0);
    wait_irq(1'b0);
    read_check(irq_reg(reg_claim), no_source, "reg_claim masked");
    apb_write(irq_reg(reg_enable), 32'(enable_ref));
    wait_irq(1'b1);

    test_name = "complete";
    apb_write(irq_reg(reg_complete), n_src + 1);
    check_latches();
    for (int k = 0; k < n_src && (latch_ref & enable_ref) != '0; k++) begin
      id = lowest_index(latch_ref & enable_ref);
      read_check(irq_reg(reg_claim), id, "reg_claim");
      apb_write(irq_reg(reg_complete), id);
      latch_ref = latch_ref & ~(n_src'(1) << id);
      check_latches();
    end
    wait_irq(1'b0);
    read_check(irq_reg(reg_claim), no_source, "reg_claim empty");

    test_name = "unmapped";
    apb_write(12'h200, lcg_next());
    read_check(12'h200, 32'h0, "prdata");
    read_check(gpio_reg(reg_led), led_ref, "reg_led");
    read_check(irq_reg(reg_enable), 32'(enable_ref), "reg_enable");
    check_latches();

    if (gpio_subsys_i.asserts_i.failed) begin
      fail_now("a concurrent assertion on the DUT failed before the end");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

/* test/gpio_subsys_asserts.sv */
`timescale 1ns/1ps

module gpio_subsys_asserts
  import gpio_pkg::*;
#(
  parameter int n_src   = 8,
  parameter int o_width = 4
) (
  input logic               clk,
  input logic               anrst,
  input logic               psel,
  input logic [11:0]        paddr,
  input logic               pready,
  input logic               pslverr,
  input logic [o_width-1:0] gpio_out,
  input logic               irq,
  input logic [n_src-1:0]   pending,
  input logic [n_src-1:0]   enable,
  input logic [n_src-1:0]   complete
);

  logic fail_pready  = 1'b0;
  logic fail_pslverr = 1'b0;
  logic fail_reset   = 1'b0;
  logic fail_irq     = 1'b0;
  logic fail_onehot  = 1'b0;
  logic mapped;
  logic failed;

  assign mapped = (paddr[11:8] == gpio_win_base[11:8]) || (paddr[11:8] == irq_win_base[11:8]);
  assign failed = fail_pready | fail_pslverr | fail_reset | fail_irq | fail_onehot;

  pready_high: assert property (@(posedge clk) pready) else begin
    $error("pready went low");
    fail_pready = 1'b1;
  end

  // an error response belongs to a selected access outside both windows.
  pslverr_unmapped: assert property (@(posedge clk) pslverr == (psel && !mapped)) else begin
    $error("pslverr does not match the address window");
    fail_pslverr = 1'b1;
  end

  led_reset: assert property (@(posedge clk) $rose(anrst) |-> gpio_out == '0) else begin
    $error("gpio_out is not zero when reset ends");
    fail_reset = 1'b1;
  end

  irq_follows: assert property (@(posedge clk) disable iff (!anrst)
    irq == $past(|(pending & enable))) else begin
    $error("irq is not the registered OR of enabled pending bits");
    fail_irq = 1'b1;
  end

  complete_onehot: assert property (@(posedge clk) disable iff (!anrst)
    $onehot0(complete)) else begin
    $error("complete has more than one bit set");
    fail_onehot = 1'b1;
  end

endmodule

/* hw/gpio_subsys.sv */
`timescale 1ns/1ps

module gpio_subsys
  import gpio_pkg::*;
#(
  parameter int e_width  = 4,
  parameter int n_input  = 2,
  parameter int n_output = 1
) (
  input  logic                        clk,
  input  logic                        anrst,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [11:0]                 paddr,
  input  logic [apb_dw-1:0]           pwdata,
  output logic [apb_dw-1:0]           prdata,
  output logic                        pready,
  output logic                        pslverr,
  input  logic [e_width*n_input-1:0]  gpio_in,
  output logic [e_width*n_output-1:0] gpio_out,
  output logic                        irq
);

  localparam int n_src = e_width * n_input;

  logic              gpio_sel;
  logic              irq_sel;
  logic [apb_dw-1:0] gpio_prdata;
  logic [apb_dw-1:0] irq_prdata;
  logic [n_src-1:0]  pending;
  logic [n_src-1:0]  complete;

  apb_decode apb_decode_i (
    .psel        (psel),
    .paddr_hi    (paddr[11:8]),
    .gpio_prdata (gpio_prdata),
    .irq_prdata  (irq_prdata),
    .gpio_sel    (gpio_sel),
    .irq_sel     (irq_sel),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr)
  );

  gpio_port #(
    .e_width  (e_width),
    .n_input  (n_input),
    .n_output (n_output)
  ) gpio_port_i (
    .clk      (clk),
    .anrst    (anrst),
    .sel      (gpio_sel),
    .penable  (penable),
    .pwrite   (pwrite),
    .offset   (paddr[3:0]),
    .pwdata   (pwdata),
    .prdata   (gpio_prdata),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .pending  (pending),
    .complete (complete)
  );

  // one interrupt source per input bit.
  irq_ctrl #(
    .n_src (n_src)
  ) irq_ctrl_i (
    .clk      (clk),
    .anrst    (anrst),
    .sel      (irq_sel),
    .penable  (penable),
    .pwrite   (pwrite),
    .offset   (paddr[3:0]),
    .pwdata   (pwdata),
    .prdata   (irq_prdata),
    .pending  (pending),
    .complete (complete),
    .irq      (irq)
  );

endmodule

/* hw/irq_ctrl.sv */
`timescale 1ns/1ps

module irq_ctrl
  import gpio_pkg::*;
#(
  parameter int n_src = 8
) (
  input  logic              clk,
  input  logic              anrst,
  input  logic              sel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [3:0]        offset,
  input  logic [apb_dw-1:0] pwdata,
  output logic [apb_dw-1:0] prdata,
  input  logic [n_src-1:0]  pending,
  output logic [n_src-1:0]  complete,
  output logic              irq
);

  logic [n_src-1:0]  enable;
  logic [n_src-1:0]  active;
  logic [n_src-1:0]  complete_next;
  logic [apb_dw-1:0] claim_id;
  logic              wr;

  assign wr     = sel & penable & pwrite;
  assign active = pending & enable;

  // ----------------------------------------
  // enable mask and irq line
  // ----------------------------------------

  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      enable <= '0;
    end else if (wr && offset == reg_enable) begin
      enable <= pwdata[n_src-1:0];
    end
  end

  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      irq <= 1'b0;
    end else begin
      irq <= |active;
    end
  end

  // ----------------------------------------
  // claim and complete
  // ----------------------------------------

  // walk down so the lowest active index is the one left standing.
  always_comb begin
    claim_id = no_source;
    for (int i = n_src - 1; i >= 0; i--) begin
      if (active[i]) begin
        claim_id = apb_dw'(i);
      end
    end
  end

  // ids past the last source match no bit and so do nothing.
  always_comb begin
    complete_next = '0;
    if (wr && offset == reg_complete) begin
      for (int i = 0; i < n_src; i++) begin
        complete_next[i] = (pwdata == apb_dw'(i));
      end
    end
  end

  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      complete <= '0;
    end else begin
      complete <= complete_next;
    end
  end

  always_comb begin
    prdata = '0;
    case (offset)
      reg_enable: prdata[n_src-1:0] = enable;
      reg_claim:  prdata = claim_id;
      default:    prdata = '0;
    endcase
  end

endmodule

/* hw/gpio_port.sv */
`timescale 1ns/1ps

module gpio_port
  import gpio_pkg::*;
#(
  parameter int e_width  = 4,
  parameter int n_input  = 2,
  parameter int n_output = 1
) (
  input  logic                        clk,
  input  logic                        anrst,
  input  logic                        sel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [3:0]                  offset,
  input  logic [apb_dw-1:0]           pwdata,
  output logic [apb_dw-1:0]           prdata,
  input  logic [e_width*n_input-1:0]  gpio_in,
  output logic [e_width*n_output-1:0] gpio_out,
  output logic [e_width*n_input-1:0]  pending,
  input  logic [e_width*n_input-1:0]  complete
);

  localparam int i_width = e_width * n_input;
  localparam int o_width = e_width * n_output;

  logic [i_width-1:0] sync_meta;
  logic [i_width-1:0] sync_level;
  logic [i_width-1:0] level_prev;
  logic [i_width-1:0] rise;
  logic [i_width-1:0] latch;
  logic [o_width-1:0] led;
  logic               led_write;

  // ----------------------------------------
  // input path
  // ----------------------------------------

  // two flops bring the pins into the clock domain, a third keeps
  // the previous level for edge detection.
  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      sync_meta  <= '0;
      sync_level <= '0;
      level_prev <= '0;
    end else begin
      sync_meta  <= gpio_in;
      sync_level <= sync_meta;
      level_prev <= sync_level;
    end
  end

  assign rise = sync_level & ~level_prev;

  // a complete pulse beats an edge that lands in the same cycle.
  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      latch <= '0;
    end else begin
      latch <= (latch | rise) & ~complete;
    end
  end

  assign pending = latch;

  // ----------------------------------------
  // output path
  // ----------------------------------------

  assign led_write = sel & penable & pwrite & (offset == reg_led);

  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      led <= '0;
    end else if (led_write) begin
      led <= pwdata[o_width-1:0];
    end
  end

  assign gpio_out = led;

  // register reads, zero extended to the bus width.
  always_comb begin
    prdata = '0;
    case (offset)
      reg_sw:  prdata[e_width-1:0] = latch[0 +: e_width];
      reg_btn: prdata[e_width-1:0] = latch[e_width +: e_width];
      reg_led: prdata[o_width-1:0] = led;
      reg_raw: prdata[i_width-1:0] = sync_level;
      default: prdata = '0;
    endcase
  end

endmodule

/* hw/apb_decode.sv */
`timescale 1ns/1ps

module apb_decode
  import gpio_pkg::*;
(
  input  logic              psel,
  input  logic [3:0]        paddr_hi,
  input  logic [apb_dw-1:0] gpio_prdata,
  input  logic [apb_dw-1:0] irq_prdata,
  output logic              gpio_sel,
  output logic              irq_sel,
  output logic [apb_dw-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  logic gpio_hit;
  logic irq_hit;

  // each window is 256 bytes, so only the top nibble of paddr matters.
  assign gpio_hit = (paddr_hi == gpio_win_base[11:8]);
  assign irq_hit  = (paddr_hi == irq_win_base[11:8]);

  assign gpio_sel = psel & gpio_hit;
  assign irq_sel  = psel & irq_hit;

  // an access outside both windows is answered here with an error.
  assign pslverr = psel & ~gpio_hit & ~irq_hit;

  // no completer ever stalls.
  assign pready = 1'b1;

  always_comb begin
    if (gpio_sel) begin
      prdata = gpio_prdata;
    end else if (irq_sel) begin
      prdata = irq_prdata;
    end else begin
      prdata = '0;
    end
  end

endmodule

/* hw/gpio_pkg.sv */
package gpio_pkg;

  // ----------------------------------------
  // bus and address map
  // ----------------------------------------

  localparam int apb_dw = 32;

  // paddr bits 11 to 8 select the window.
  localparam logic [11:0] gpio_win_base = 12'h000;
  localparam logic [11:0] irq_win_base  = 12'h100;

  // ----------------------------------------
  // register offsets within a window
  // ----------------------------------------

  localparam logic [3:0] reg_sw  = 4'h0;
  localparam logic [3:0] reg_btn = 4'h4;
  localparam logic [3:0] reg_led = 4'h8;
  localparam logic [3:0] reg_raw = 4'hC;

  localparam logic [3:0] reg_enable   = 4'h0;
  localparam logic [3:0] reg_claim    = 4'h4;
  localparam logic [3:0] reg_complete = 4'h8;

  // claim value when nothing is enabled and pending.
  localparam logic [apb_dw-1:0] no_source = 32'hFFFF_FFFF;

endpackage
